/* tcam_macros.svh */
`ifndef TCAM_MACROS_SVH
`define TCAM_MACROS_SVH

// search key layout.
`define TCAM_KEY_BITS 144
`define TCAM_FIELD_BITS 2
`define TCAM_FIELD_COUNT 72

// field number as seen on the table write port.
`define TCAM_FIELD_IDX_BITS 7

// entry space.
`define TCAM_ENTRY_COUNT 256
`define TCAM_INDEX_BITS 8

// search strobe to result valid, in cycles.
`define TCAM_PIPE_DEPTH 3

`endif

/* tcam_key_pkg.sv */
`include "tcam_macros.svh"

package tcam_key_pkg;

  typedef logic [`TCAM_FIELD_BITS-1:0] field_t; // one field value.

  // field 0 sits in the lowest bits of the key.
  typedef field_t [`TCAM_FIELD_COUNT-1:0] field_array_t;

  // the same key bits, as a flat word or as per-field values.
  typedef union packed {
    logic [`TCAM_KEY_BITS-1:0] flat;
    field_array_t fields;
  } search_key_t;

endpackage

/* tcam_result_pkg.sv */
`include "tcam_macros.svh"

package tcam_result_pkg;

  typedef logic [`TCAM_ENTRY_COUNT-1:0] match_vec_t; // bit e is entry e.
  typedef logic [`TCAM_INDEX_BITS-1:0] entry_index_t;

endpackage

/* search_key_stage.sv */
`timescale 1ns/1ps

module search_key_stage
  import tcam_key_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        search,
  input  search_key_t key,
  output search_key_t key_q,
  output logic        key_valid
);

  // key register, loaded only on a search.
  always_ff @(posedge clk) begin
    if (search) begin
      key_q.flat <= key.flat;
    end
  end

  // strobe follows the key by one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      key_valid <= 1'b0;
    end else begin
      key_valid <= search;
    end
  end

endmodule

/* field_match_tables.sv */
`timescale 1ns/1ps
`include "tcam_macros.svh"

module field_match_tables
  import tcam_key_pkg::*, tcam_result_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  search_key_t                     key_q,
  input  logic                            key_valid,
  input  logic                            wr_en,
  input  logic [`TCAM_FIELD_IDX_BITS-1:0] wr_field,
  input  field_t                          wr_value,
  input  match_vec_t                      wr_vector,
  output match_vec_t                      match_q,
  output logic                            match_valid
);

  localparam int FIELD_VALUES = 1 << `TCAM_FIELD_BITS;

  // one stored vector per field and field value.
  match_vec_t tables [`TCAM_FIELD_COUNT][FIELD_VALUES];

  // write staged for one cycle before it reaches the tables.
  logic                            wr_pend_en;
  logic [`TCAM_FIELD_IDX_BITS-1:0] wr_pend_field;
  field_t                          wr_pend_value;
  match_vec_t                      wr_pend_vector;

  match_vec_t sel_vec;
  match_vec_t match_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend_en <= 1'b0;
    end else begin
      wr_pend_en <= wr_en && (wr_field < `TCAM_FIELD_COUNT); // drop fields out of range.
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      wr_pend_field  <= wr_field;
      wr_pend_value  <= wr_value;
      wr_pend_vector <= wr_vector;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int f = 0; f < `TCAM_FIELD_COUNT; f++) begin
        for (int v = 0; v < FIELD_VALUES; v++) begin
          tables[f][v] <= '0;
        end
      end
    end else if (wr_pend_en) begin
      tables[wr_pend_field][wr_pend_value] <= wr_pend_vector; // whole vector replaced.
    end
  end

  // select per field, with the staged write taking priority over the table.
  // a search captured on the same edge as a write therefore sees that write.
  always_comb begin
    match_d = '1;
    for (int f = 0; f < `TCAM_FIELD_COUNT; f++) begin
      sel_vec = tables[f][key_q.fields[f]];
      if (wr_pend_en && int'(wr_pend_field) == f && wr_pend_value == key_q.fields[f]) begin
        sel_vec = wr_pend_vector;
      end
      match_d = match_d & sel_vec;
    end
  end

  always_ff @(posedge clk) begin
    if (key_valid) begin
      match_q <= match_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= key_valid;
    end
  end

endmodule

/* match_priority_encoder.sv */
`timescale 1ns/1ps
`include "tcam_macros.svh"

module match_priority_encoder
  import tcam_result_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  match_vec_t   match_q,
  input  logic         match_valid,
  output logic         result_valid,
  output logic         hit,
  output entry_index_t index,
  output match_vec_t   match_vector
);

  logic         any_d;
  entry_index_t index_d;

  // lowest set bit wins, scanning down so the last assignment is the smallest index.
  always_comb begin
    any_d   = |match_q;
    index_d = '0; // stays 0 on a miss.
    for (int e = `TCAM_ENTRY_COUNT - 1; e >= 0; e--) begin
      if (match_q[e]) begin
        index_d = entry_index_t'(e);
      end
    end
  end

  // result fields hold between searches.
  always_ff @(posedge clk) begin
    if (match_valid) begin
      hit          <= any_d;
      index        <= index_d;
      match_vector <= match_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= match_valid;
    end
  end

endmodule

/* tcam_top.sv */
`timescale 1ns/1ps
`include "tcam_macros.svh"

module tcam_top
  import tcam_key_pkg::*, tcam_result_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,

  // search side.
  input  logic                            search,
  input  search_key_t                     key,

  // table write port.
  input  logic                            wr_en,
  input  logic [`TCAM_FIELD_IDX_BITS-1:0] wr_field,
  input  field_t                          wr_value,
  input  match_vec_t                      wr_vector,

  // result, three cycles after the search.
  output logic                            result_valid,
  output logic                            hit,
  output entry_index_t                    index,
  output match_vec_t                      match_vector
);

  search_key_t key_q;
  logic        key_valid;
  match_vec_t  match_q;
  logic        match_valid;

  search_key_stage u_key (
    .clk       (clk),
    .rst       (rst),
    .search    (search),
    .key       (key),
    .key_q     (key_q),
    .key_valid (key_valid)
  );

  field_match_tables u_tables (
    .clk         (clk),
    .rst         (rst),
    .key_q       (key_q),
    .key_valid   (key_valid),
    .wr_en       (wr_en),
    .wr_field    (wr_field),
    .wr_value    (wr_value),
    .wr_vector   (wr_vector),
    .match_q     (match_q),
    .match_valid (match_valid)
  );

  match_priority_encoder u_pe (
    .clk          (clk),
    .rst          (rst),
    .match_q      (match_q),
    .match_valid  (match_valid),
    .result_valid (result_valid),
    .hit          (hit),
    .index        (index),
    .match_vector (match_vector)
  );

endmodule

/* tb_tcam_top.sv */
`timescale 1ns/1ps
`include "tcam_macros.svh"

module tb_tcam_top
  import tcam_key_pkg::*, tcam_result_pkg::*;
();

  logic                            clk;
  logic                            rst;
  logic                            search;
  search_key_t                     key;
  logic                            wr_en;
  logic [`TCAM_FIELD_IDX_BITS-1:0] wr_field;
  field_t                          wr_value;
  match_vec_t                      wr_vector;
  logic                            result_valid;
  logic                            hit;
  entry_index_t                    index;
  match_vec_t                      match_vector;

  match_vec_t   shadow [`TCAM_FIELD_COUNT][4]; // copy of every stored vector.
  match_vec_t   exp_vec_q [$];
  logic         exp_hit_q [$];
  entry_index_t exp_idx_q [$];
  int           errors, checks, issued, results_seen, errors_before;
  integer       seed;
  logic         last_hit;
  entry_index_t last_index;
  match_vec_t   last_vector;
  search_key_t  key_a, key_b, key_c, key_d;
  field_t       p;
  int           rf, rb;
  field_t       rv;
  match_vec_t   vec;

  tcam_top dut0 (
    .clk (clk), .rst (rst), .search (search), .key (key),
    .wr_en (wr_en), .wr_field (wr_field), .wr_value (wr_value), .wr_vector (wr_vector),
    .result_valid (result_valid), .hit (hit), .index (index), .match_vector (match_vector)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // every search shows up exactly three edges later.
  result_timing: assert property (@(posedge clk) disable iff (rst)
      result_valid == $past(search, `TCAM_PIPE_DEPTH))
    else begin
      errors++;
      $display("mismatch at %0t: result_valid expected %0b got %0b", $time,
               !$sampled(result_valid), $sampled(result_valid));
    end

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  // entry e matches when every field's selected vector has bit e set.
  function automatic match_vec_t expected_match(input search_key_t k);
    match_vec_t m;
    for (int e = 0; e < `TCAM_ENTRY_COUNT; e++) begin
      m[e] = 1'b1;
      for (int f = 0; f < `TCAM_FIELD_COUNT; f++) begin
        if (!shadow[f][k.fields[f]][e]) m[e] = 1'b0;
      end
    end
    return m;
  endfunction

  function automatic entry_index_t lowest_entry(input match_vec_t m);
    entry_index_t idx;
    logic found;
    idx = '0;
    found = 1'b0;
    for (int e = 0; e < `TCAM_ENTRY_COUNT; e++) begin
      if (m[e] && !found) begin
        idx = entry_index_t'(e);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic search_key_t random_key();
    search_key_t k;
    for (int f = 0; f < `TCAM_FIELD_COUNT; f++) k.fields[f] = field_t'($random(seed));
    return k;
  endfunction

  // a write and a search driven together are sampled on the same edge.
  task automatic drive_cycle(input logic do_search, input search_key_t k, input logic do_write,
                             input int f, input field_t v, input match_vec_t wvec);
    match_vec_t m;
    @(negedge clk);
    search    = do_search;
    key       = k;
    wr_en     = do_write;
    wr_field  = f[`TCAM_FIELD_IDX_BITS-1:0];
    wr_value  = v;
    wr_vector = wvec;
    if (do_write) shadow[f][v] = wvec;
    if (do_search) begin
      m = expected_match(k);
      exp_vec_q.push_back(m);
      exp_hit_q.push_back(|m);
      exp_idx_q.push_back(lowest_entry(m));
      issued++;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    search = 1'b0;
    wr_en  = 1'b0;
  endtask

  task automatic issue_search(input search_key_t k);
    drive_cycle(1'b1, k, 1'b0, 0, '0, '0);
  endtask

  task automatic set_entry_bit(input int e, input int f, input field_t v, input logic b);
    match_vec_t w;
    w = shadow[f][v];
    w[e] = b;
    drive_cycle(1'b0, key, 1'b1, f, v, w);
  endtask

  task automatic program_exact(input int e, input search_key_t k);
    for (int f = 0; f < `TCAM_FIELD_COUNT; f++) begin
      for (int v = 0; v < 4; v++) set_entry_bit(e, f, field_t'(v), v == k.fields[f]);
    end
    idle_cycle();
  endtask

  task automatic wait_for_results(input int target);
    int cycles;
    cycles = 0;
    while (results_seen < target && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (results_seen < target) begin
      errors++;
      $display("timeout waiting for result %0d, only %0d arrived", target, results_seen);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %s", num, name, (errors == errors_before) ? "pass" : "fail");
    errors_before = errors;
  endtask

  // the scoreboard samples mid-cycle where the outputs are stable.
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      if (exp_vec_q.size() == 0) begin
        errors++;
        $display("result at %0t arrived with no search outstanding", $time);
      end else begin
        check_value("hit", exp_hit_q.pop_front(), hit);
        check_value("index", exp_idx_q.pop_front(), index);
        check_value("match_vector", exp_vec_q.pop_front(), match_vector);
        last_hit    = hit;
        last_index  = index;
        last_vector = match_vector;
        results_seen++;
      end
    end
  end

  initial begin
    seed = 32'h6b20_6f74;
    {errors, checks, issued, results_seen, errors_before} = '0;
    for (int f = 0; f < `TCAM_FIELD_COUNT; f++) begin
      for (int v = 0; v < 4; v++) shadow[f][v] = '0;
    end
    rst = 1'b1;
    search = 1'b0;
    key = '0;
    wr_en = 1'b0;
    wr_field = '0;
    wr_value = '0;
    wr_vector = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    check_value("result_valid", 1'b0, result_valid);
    issue_search(random_key());
    idle_cycle();
    wait_for_results(issued);
    check_value("hit", 1'b0, last_hit);
    check_value("match_vector", '0, last_vector);
    report_test(1, "reset");

    key_a = random_key();
    program_exact(5, key_a);
    key_d = key_a;
    key_d.fields[40] = key_a.fields[40] ^ 2'b01; // one field off.
    issue_search(key_a);
    idle_cycle();
    wait_for_results(issued);
    check_value("hit", 1'b1, last_hit);
    check_value("index", 8'd5, last_index);
    issue_search(key_d);
    idle_cycle();
    wait_for_results(issued);
    check_value("hit", 1'b0, last_hit);
    report_test(2, "exact match");

    p = field_t'($random(seed));
    for (int f = 0; f < `TCAM_FIELD_COUNT; f++) begin
      for (int v = 0; v < 4; v++) set_entry_bit(9, f, field_t'(v), f != 0 || v == p);
    end
    key_c = random_key();
    key_c.fields[0] = p;
    key_d = key_c;
    key_d.fields[0] = p + 2'd1;
    issue_search(key_c);
    idle_cycle();
    wait_for_results(issued);
    check_value("match_vector[9]", 1'b1, last_vector[9]);
    issue_search(key_d);
    idle_cycle();
    wait_for_results(issued);
    check_value("match_vector[9]", 1'b0, last_vector[9]);
    report_test(3, "dont care");

    key_b = random_key();
    program_exact(3, key_b);
    program_exact(200, key_b);
    issue_search(key_b);
    idle_cycle();
    wait_for_results(issued);
    check_value("index", 8'd3, last_index);
    check_value("match_vector[3]", 1'b1, last_vector[3]);
    check_value("match_vector[200]", 1'b1, last_vector[200]);
    report_test(4, "priority");

    for (int i = 0; i < 10; i++) begin
      rf = {$random(seed)} % `TCAM_FIELD_COUNT;
      rv = field_t'($random(seed));
      rb = {$random(seed)} % `TCAM_ENTRY_COUNT;
      vec = shadow[rf][rv];
      vec[rb] = ~vec[rb];
      drive_cycle(1'b0, key, 1'b1, rf, rv, vec);
    end
    for (int i = 0; i < 24; i++) begin
      case ({$random(seed)} % 4)
        0: key_d = key_a;
        1: key_d = key_b;
        2: key_d = key_c;
        default: key_d = random_key();
      endcase
      if (i == 12) begin
        vec = shadow[0][key_c.fields[0]];
        vec[9] = ~vec[9]; // flips entry 9 for the search on the same edge.
        drive_cycle(1'b1, key_c, 1'b1, 0, key_c.fields[0], vec);
      end else begin
        issue_search(key_d);
      end
    end
    idle_cycle();
    wait_for_results(issued);
    report_test(5, "pipeline");

    $display("summary: %0d checks, %0d errors, %0d searches, %0d results", checks, errors,
             issued, results_seen);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tcam_top.f */
+incdir+.
tcam_key_pkg.sv
tcam_result_pkg.sv
search_key_stage.sv
field_match_tables.sv
match_priority_encoder.sv
tcam_top.sv
tb_tcam_top.sv

/* Bender.yml */
package:
  name: tcam_top

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - tcam_key_pkg.sv
      - tcam_result_pkg.sv
      - search_key_stage.sv
      - field_match_tables.sv
      - match_priority_encoder.sv
      - tcam_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tcam_top.sv
